// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_tex_unit
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ALL TESTS PASSED
COMMON     := --timing --timescale 1ns/100ps --top-module $(TOP)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert -j 0 $(COMMON) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/tex_pkg.sv
`default_nettype none

package tex_pkg;

    // warp geometry
    localparam int NUM_THREADS = 2;
    localparam int NW_BITS     = 2;
    localparam int NR_BITS     = 5;
    localparam int PC_BITS     = 32;

    // texture units and their control registers
    localparam int NUM_TEX_UNITS = 2;
    localparam int TEX_UNIT_BITS = 1;
    localparam int CSR_ADDR_BITS = 12;
    localparam int CSR_WIDTH     = 32;

    localparam logic [CSR_ADDR_BITS-1:0] CSR_TEX_BEGIN = 12'h7C0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_TEX_END   = 12'h7CF;

    // coordinates and sizes
    localparam int COORD_BITS    = 16;
    localparam int MAX_DIM_LOG2  = 8;
    localparam int DIM_LOG2_BITS = $clog2(MAX_DIM_LOG2 + 1);

    // texel storage
    localparam int MEM_ADDR_BITS = 10;
    localparam int MEM_DEPTH     = 1024;
    localparam int TEXEL_BITS    = 32;

    // request to response, in cycles
    localparam int TEX_LATENCY = 3;

    // register offsets inside one unit, 6 and 7 reserved
    typedef enum logic [2:0] {
        CSR_OFS_ADDR   = 3'd0,
        CSR_OFS_FORMAT = 3'd1,
        CSR_OFS_WIDTH  = 3'd2,
        CSR_OFS_HEIGHT = 3'd3,
        CSR_OFS_WRAP_U = 3'd4,
        CSR_OFS_WRAP_V = 3'd5
    } tex_csr_e;

    typedef enum logic [1:0] {
        WRAP_CLAMP  = 2'd0,
        WRAP_REPEAT = 2'd1,
        WRAP_MIRROR = 2'd2
    } wrap_mode_e;

    typedef enum logic {
        FMT_RGBA8 = 1'b0,
        FMT_R8    = 1'b1
    } tex_format_e;

endpackage

`default_nettype wire

// File: project.f
common/tex_pkg.sv
tex/tex_csr.sv
tex/tex_addr_gen.sv
tex/tex_mem.sv
tex/tex_unpack.sv
tex/tex_unit.sv
test/tb_clock_gen.sv
test/tex_unit_properties.sv
test/tb_tex_unit.sv

// File: test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // released just after the 8th rising edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/tb_tex_unit.sv
`default_nettype none

module tb_tex_unit
    import tex_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ENTRIES = 12;
    localparam int TOTAL       = 2 * NUM_ENTRIES;
    localparam int MAX_STALL   = 3;
    // reset, memory load and register writes run before the stream
    localparam int TIMEOUT_CYCLES = 16 + MEM_DEPTH + 32
        + TOTAL * TEX_LATENCY + TOTAL * MAX_STALL + 200;

    // unit 0 is RGBA8 16x8 repeat, unit 1 is R8 8x4 clamp u and mirror v
    localparam int          CFG_BASE   [NUM_TEX_UNITS] = '{'h040, 'h300};
    localparam tex_format_e CFG_FORMAT [NUM_TEX_UNITS] = '{FMT_RGBA8, FMT_R8};
    localparam int          CFG_W_LOG2 [NUM_TEX_UNITS] = '{4, 3};
    localparam int          CFG_H_LOG2 [NUM_TEX_UNITS] = '{3, 2};
    localparam wrap_mode_e  CFG_WRAP_U [NUM_TEX_UNITS] = '{WRAP_REPEAT, WRAP_CLAMP};
    localparam wrap_mode_e  CFG_WRAP_V [NUM_TEX_UNITS] = '{WRAP_REPEAT, WRAP_MIRROR};

    // unit, u0, v0, u1, v1, tmask, wid, pc, rd, wb
    localparam int STIM [NUM_ENTRIES][10] = '{
        '{0,    0,    0,     15,     7, 3, 0, 'h100,  1, 1},
        '{0,   16,    8,     -1,    -1, 3, 1, 'h104,  2, 1},
        '{0,  -17,   -9,     35,   100, 3, 2, 'h108,  3, 0},
        '{1,    0,    0,      1,     0, 3, 3, 'h10C,  4, 1},
        '{1,    2,    0,      3,     0, 3, 0, 'h110,  5, 1},
        '{1,   -5,    4,     20,     5, 3, 1, 'h114,  6, 1},
        '{0,    5,    3,      6,     3, 1, 2, 'h118,  7, 0},
        '{1,    7,   -1,      4,    -6, 3, 3, 'h11C,  8, 1},
        '{0, 1000, -300, -32768, 32767, 3, 0, 'h120,  9, 1},
        '{1,    9,   11,     -2,     7, 2, 1, 'h124, 10, 0},
        '{0,    8,    4,      9,     5, 3, 2, 'h128, 11, 1},
        '{1,    6,    2,      5,     3, 3, 3, 'h12C, 12, 1}
    };

    logic                                    clk;
    logic                                    rst_n;
    logic                                    csr_wr_en;
    logic [CSR_ADDR_BITS-1:0]                csr_wr_addr;
    logic [CSR_WIDTH-1:0]                    csr_wr_data;
    logic                                    mem_wr_en;
    logic [MEM_ADDR_BITS-1:0]                mem_wr_addr;
    logic [TEXEL_BITS-1:0]                   mem_wr_data;
    logic                                    req_valid;
    logic                                    req_ready;
    logic [TEX_UNIT_BITS-1:0]                req_unit;
    logic [NW_BITS-1:0]                      req_wid;
    logic [NUM_THREADS-1:0]                  req_tmask;
    logic [PC_BITS-1:0]                      req_pc;
    logic [NR_BITS-1:0]                      req_rd;
    logic                                    req_wb;
    logic [NUM_THREADS-1:0][COORD_BITS-1:0]  req_u;
    logic [NUM_THREADS-1:0][COORD_BITS-1:0]  req_v;
    logic                                    rsp_valid;
    logic                                    rsp_ready;
    logic [NW_BITS-1:0]                      rsp_wid;
    logic [NUM_THREADS-1:0]                  rsp_tmask;
    logic [PC_BITS-1:0]                      rsp_pc;
    logic [NR_BITS-1:0]                      rsp_rd;
    logic                                    rsp_wb;
    logic [NUM_THREADS-1:0][TEXEL_BITS-1:0]  rsp_data;

    logic [TEXEL_BITS-1:0] shadow    [MEM_DEPTH];
    logic [TEXEL_BITS-1:0] exp_color [NUM_ENTRIES][NUM_THREADS];
    logic [31:0]           rng_state = 32'd29;
    logic                  random_ready;
    int                    expected_q [$];
    int                    rsp_count = 0;
    int                    cycles = 0;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tex_unit dut_i (
        .clk (clk), .rst_n (rst_n),
        .csr_wr_en (csr_wr_en), .csr_wr_addr (csr_wr_addr), .csr_wr_data (csr_wr_data),
        .mem_wr_en (mem_wr_en), .mem_wr_addr (mem_wr_addr), .mem_wr_data (mem_wr_data),
        .req_valid (req_valid), .req_ready (req_ready), .req_unit (req_unit),
        .req_wid (req_wid), .req_tmask (req_tmask), .req_pc (req_pc), .req_rd (req_rd),
        .req_wb (req_wb), .req_u (req_u), .req_v (req_v),
        .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp_wid (rsp_wid),
        .rsp_tmask (rsp_tmask), .rsp_pc (rsp_pc), .rsp_rd (rsp_rd), .rsp_wb (rsp_wb),
        .rsp_data (rsp_data)
    );

    bind tex_unit tex_unit_properties props_i (
        .clk (clk), .rst_n (rst_n), .req_ready (req_ready),
        .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp_wid (rsp_wid),
        .rsp_tmask (rsp_tmask), .rsp_pc (rsp_pc), .rsp_rd (rsp_rd), .rsp_wb (rsp_wb),
        .rsp_data (rsp_data)
    );

    function automatic logic [31:0] xorshift_next();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int ref_wrap(input int c, input int size, input wrap_mode_e mode);
        int t;
        int res;
        if (mode == WRAP_REPEAT) begin
            t   = c % size;
            res = (t < 0) ? t + size : t;
        end else if (mode == WRAP_MIRROR) begin
            t = c % (2 * size);
            if (t < 0) begin
                t = t + 2 * size;
            end
            res = (t < size) ? t : 2 * size - 1 - t;
        end else begin
            res = (c < 0) ? 0 : ((c >= size) ? size - 1 : c);
        end
        return res;
    endfunction

    function automatic logic [TEXEL_BITS-1:0] ref_color(input int unit, input int u, input int v);
        int                    width;
        int                    idx;
        logic [TEXEL_BITS-1:0] w;
        width = 1 << CFG_W_LOG2[unit];
        idx   = ref_wrap(v, 1 << CFG_H_LOG2[unit], CFG_WRAP_V[unit]) * width
              + ref_wrap(u, width, CFG_WRAP_U[unit]);
        if (CFG_FORMAT[unit] == FMT_R8) begin
            w = shadow[(CFG_BASE[unit] + idx / 4) % MEM_DEPTH];
            return {8'hFF, 16'h0000, w[8 * (idx % 4) +: 8]};
        end
        return shadow[(CFG_BASE[unit] + idx) % MEM_DEPTH];
    endfunction

    task automatic stop_failed();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failing check");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0b, actual %0b", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_color(input string name, input int lane,
                               input logic [TEXEL_BITS-1:0] exp,
                               input logic [TEXEL_BITS-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s lane %0d: expected %08h, actual %08h", name, lane, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_meta(input string name,
                              input logic [NW_BITS-1:0] exp_wid, input logic [NW_BITS-1:0] act_wid,
                              input logic [NUM_THREADS-1:0] exp_tmask,
                              input logic [NUM_THREADS-1:0] act_tmask,
                              input logic [PC_BITS-1:0] exp_pc, input logic [PC_BITS-1:0] act_pc,
                              input logic [NR_BITS-1:0] exp_rd, input logic [NR_BITS-1:0] act_rd,
                              input logic exp_wb, input logic act_wb);
        if ({act_wid, act_tmask, act_pc, act_rd, act_wb}
                !== {exp_wid, exp_tmask, exp_pc, exp_rd, exp_wb}) begin
            $display("[ERROR] %s: expected %s, actual %s", name,
                     $sformatf("wid=%0h mask=%0h pc=%0h rd=%0d wb=%0b",
                               exp_wid, exp_tmask, exp_pc, exp_rd, exp_wb),
                     $sformatf("wid=%0h mask=%0h pc=%0h rd=%0d wb=%0b",
                               act_wid, act_tmask, act_pc, act_rd, act_wb));
            stop_failed();
        end
    endtask

    // drives happen 1 ns after a rising edge
    task automatic csr_write(input logic [CSR_ADDR_BITS-1:0] addr,
                             input logic [CSR_WIDTH-1:0] data);
        csr_wr_en   = 1'b1;
        csr_wr_addr = addr;
        csr_wr_data = data;
        @(posedge clk);
        #1;
        csr_wr_en = 1'b0;
    endtask

    task automatic fill_memory();
        logic [TEXEL_BITS-1:0] w;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            w           = xorshift_next();
            shadow[a]   = w;
            mem_wr_en   = 1'b1;
            mem_wr_addr = MEM_ADDR_BITS'(a);
            mem_wr_data = w;
            @(posedge clk);
            #1;
        end
        mem_wr_en = 1'b0;
    endtask

    task automatic program_unit(input int unit);
        logic [CSR_ADDR_BITS-1:0] a;
        a = CSR_TEX_BEGIN + CSR_ADDR_BITS'(8 * unit);
        csr_write(a + CSR_ADDR_BITS'(CSR_OFS_ADDR), CSR_WIDTH'(CFG_BASE[unit]));
        csr_write(a + CSR_ADDR_BITS'(CSR_OFS_FORMAT), CSR_WIDTH'(CFG_FORMAT[unit]));
        csr_write(a + CSR_ADDR_BITS'(CSR_OFS_WIDTH), CSR_WIDTH'(CFG_W_LOG2[unit]));
        csr_write(a + CSR_ADDR_BITS'(CSR_OFS_HEIGHT), CSR_WIDTH'(CFG_H_LOG2[unit]));
        csr_write(a + CSR_ADDR_BITS'(CSR_OFS_WRAP_U), CSR_WIDTH'(CFG_WRAP_U[unit]));
        csr_write(a + CSR_ADDR_BITS'(CSR_OFS_WRAP_V), CSR_WIDTH'(CFG_WRAP_V[unit]));
    endtask

    // reserved offsets and out-of-range addresses
    task automatic write_ignored_addresses();
        csr_write(12'h7C6, 32'hFFFF_FFFF);
        csr_write(12'h7C7, 32'hFFFF_FFFF);
        csr_write(12'h7CE, 32'hFFFF_FFFF);
        csr_write(12'h7CF, 32'hFFFF_FFFF);
        csr_write(12'h7BF, 32'hFFFF_FFFF);
        csr_write(12'h7D0, 32'hFFFF_FFFF);
        csr_write(12'hFC0, 32'hFFFF_FFFF);
    endtask

    task automatic drive_request(input int e);
        req_valid = 1'b1;
        req_unit  = TEX_UNIT_BITS'(STIM[e][0]);
        for (int t = 0; t < NUM_THREADS; t++) begin
            req_u[t] = COORD_BITS'(STIM[e][1 + 2 * t]);
            req_v[t] = COORD_BITS'(STIM[e][2 + 2 * t]);
        end
        req_tmask = NUM_THREADS'(STIM[e][5]);
        req_wid   = NW_BITS'(STIM[e][6]);
        req_pc    = PC_BITS'(STIM[e][7]);
        req_rd    = NR_BITS'(STIM[e][8]);
        req_wb    = 1'(STIM[e][9]);
    endtask

    task automatic check_response(input int e, input string name);
        check_meta(name, NW_BITS'(STIM[e][6]), rsp_wid, NUM_THREADS'(STIM[e][5]), rsp_tmask,
                   PC_BITS'(STIM[e][7]), rsp_pc, NR_BITS'(STIM[e][8]), rsp_rd,
                   1'(STIM[e][9]), rsp_wb);
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (STIM[e][5][t]) begin
                check_color(name, t, exp_color[e][t], rsp_data[t]);
            end
        end
    endtask

    // responses are sampled mid-cycle, where every signal is settled
    initial begin : response_monitor
        int e;
        forever begin
            @(posedge clk);
            #3;
            if (rsp_valid === 1'b1 && rsp_ready === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("a response arrived with no request outstanding");
                    stop_failed();
                end else begin
                    e = expected_q.pop_front();
                    check_response(e, $sformatf("pass %0d entry %0d", rsp_count / NUM_ENTRIES, e));
                    rsp_count++;
                end
            end
        end
    end

    // random back-pressure, never low for more than MAX_STALL cycles in a row
    initial begin : ready_driver
        int          low_run;
        logic [31:0] r;
        low_run = 0;
        forever begin
            @(posedge clk);
            #1;
            if (random_ready) begin
                r = xorshift_next();
                if (!r[0] && low_run < MAX_STALL) begin
                    rsp_ready = 1'b0;
                    low_run++;
                end else begin
                    rsp_ready = 1'b1;
                    low_run   = 0;
                end
            end else begin
                rsp_ready = 1'b1;
            end
        end
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d responses received",
                 cycles, rsp_count, TOTAL);
        stop_failed();
    end

    initial begin : main_sequence
        int k;
        int e;
        csr_wr_en    = 1'b0;
        csr_wr_addr  = '0;
        csr_wr_data  = '0;
        mem_wr_en    = 1'b0;
        mem_wr_addr  = '0;
        mem_wr_data  = '0;
        req_valid    = 1'b0;
        req_unit     = '0;
        req_wid      = '0;
        req_tmask    = '0;
        req_pc       = '0;
        req_rd       = '0;
        req_wb       = 1'b0;
        req_u        = '0;
        req_v        = '0;
        rsp_ready    = 1'b1;
        random_ready = 1'b0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        check_flag("rsp_valid after reset", 1'b0, rsp_valid);
        check_flag("req_ready after reset", 1'b1, req_ready);
        fill_memory();
        program_unit(0);
        program_unit(1);
        write_ignored_addresses();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                exp_color[i][t] = ref_color(STIM[i][0], STIM[i][1 + 2 * t], STIM[i][2 + 2 * t]);
            end
        end
        // table applied twice, back to back
        k = 0;
        while (k < TOTAL) begin
            e = k % NUM_ENTRIES;
            drive_request(e);
            #2;
            if (req_ready === 1'b1) begin
                expected_q.push_back(e);
                k++;
                random_ready = (k >= NUM_ENTRIES);
            end
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        while (rsp_count < TOTAL) begin
            @(posedge clk);
        end
        repeat (2 * TEX_LATENCY) @(posedge clk);
        if (rsp_count == TOTAL && expected_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("response count %0d does not match %0d requests", rsp_count, TOTAL);
            stop_failed();
        end
    end

endmodule

`default_nettype wire

// File: test/tex_unit_properties.sv
`default_nettype none

module tex_unit_properties
    import tex_pkg::*;
(
    input wire                                    clk,
    input wire                                    rst_n,
    input wire                                    req_ready,
    input wire                                    rsp_valid,
    input wire                                    rsp_ready,
    input wire [NW_BITS-1:0]                      rsp_wid,
    input wire [NUM_THREADS-1:0]                  rsp_tmask,
    input wire [PC_BITS-1:0]                      rsp_pc,
    input wire [NR_BITS-1:0]                      rsp_rd,
    input wire                                    rsp_wb,
    input wire [NUM_THREADS-1:0][TEXEL_BITS-1:0]  rsp_data
);

    timeunit 1ns;
    timeprecision 100ps;

    // a stalled response keeps every field
    a_hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_wid) && $stable(rsp_tmask)
            && $stable(rsp_pc) && $stable(rsp_rd) && $stable(rsp_wb) && $stable(rsp_data)))
        else $error("response fields changed while the response was stalled");

    a_ready_follows_stall: assert property (@(posedge clk) disable iff (!rst_n)
        req_ready == !(rsp_valid && !rsp_ready))
        else $error("req_ready does not match the stall condition");

    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !rsp_valid ##1 !rsp_valid ##1 !rsp_valid)
        else $error("rsp_valid rose too early after reset");

endmodule

`default_nettype wire

// File: tex/tex_addr_gen.sv
`default_nettype none

module tex_addr_gen
    import tex_pkg::*;
(
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire                                       advance,
    input  wire                                       in_valid,
    input  wire  [NUM_THREADS-1:0][COORD_BITS-1:0]    u,
    input  wire  [NUM_THREADS-1:0][COORD_BITS-1:0]    v,
    input  wire  [MEM_ADDR_BITS-1:0]                  base,
    input  wire  [DIM_LOG2_BITS-1:0]                  width_log2,
    input  wire  [DIM_LOG2_BITS-1:0]                  height_log2,
    input  wire wrap_mode_e                           wrap_u,
    input  wire wrap_mode_e                           wrap_v,
    input  wire tex_format_e                          format,
    output logic [NUM_THREADS-1:0][MEM_ADDR_BITS-1:0] word_addr,
    output logic [NUM_THREADS-1:0][1:0]               byte_sel,
    output logic                                      out_valid
);

    // signed coordinate into 0 .. size-1, sizes are powers of two
    function automatic logic [COORD_BITS-1:0] wrap_coord(
        input logic [COORD_BITS-1:0]    c,
        input logic [DIM_LOG2_BITS-1:0] size_log2,
        input wrap_mode_e               mode
    );
        logic [COORD_BITS:0] size;
        logic [COORD_BITS:0] cx;
        logic [COORD_BITS:0] t;
        logic [COORD_BITS:0] res;
        size = {{COORD_BITS{1'b0}}, 1'b1} << size_log2;
        cx   = {c[COORD_BITS-1], c};
        case (mode)
            WRAP_REPEAT: res = cx & (size - 1'b1);
            WRAP_MIRROR: begin
                t   = cx & ((size << 1) - 1'b1);
                res = (t < size) ? t : ((size << 1) - 1'b1 - t);
            end
            default: begin
                if (c[COORD_BITS-1]) begin
                    res = '0;
                end else if (cx >= size) begin
                    res = size - 1'b1;
                end else begin
                    res = cx;
                end
            end
        endcase
        return res[COORD_BITS-1:0];
    endfunction

    logic [NUM_THREADS-1:0][MEM_ADDR_BITS-1:0] addr_d;
    logic [NUM_THREADS-1:0][1:0]               sel_d;

    always_comb begin : addr_calc
        logic [COORD_BITS-1:0]    uw;
        logic [COORD_BITS-1:0]    vw;
        logic [MEM_ADDR_BITS+1:0] idx;
        for (int t = 0; t < NUM_THREADS; t++) begin
            uw  = wrap_coord(u[t], width_log2, wrap_u);
            vw  = wrap_coord(v[t], height_log2, wrap_v);
            // only the low index bits survive the modulo
            idx = (MEM_ADDR_BITS+2)'((vw << width_log2) + uw);
            if (format == FMT_R8) begin
                addr_d[t] = base + idx[MEM_ADDR_BITS+1:2];
                sel_d[t]  = idx[1:0];
            end else begin
                addr_d[t] = base + idx[MEM_ADDR_BITS-1:0];
                sel_d[t]  = 2'b00;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            word_addr <= addr_d;
            byte_sel  <= sel_d;
        end
    end

endmodule

`default_nettype wire

// File: tex/tex_csr.sv
`default_nettype none

module tex_csr
    import tex_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          csr_wr_en,
    input  wire  [CSR_ADDR_BITS-1:0]     csr_wr_addr,
    input  wire  [CSR_WIDTH-1:0]         csr_wr_data,
    input  wire  [TEX_UNIT_BITS-1:0]     rd_unit,
    output logic [MEM_ADDR_BITS-1:0]     rd_base,
    output tex_format_e                  rd_format,
    output logic [DIM_LOG2_BITS-1:0]     rd_width_log2,
    output logic [DIM_LOG2_BITS-1:0]     rd_height_log2,
    output wrap_mode_e                   rd_wrap_u,
    output wrap_mode_e                   rd_wrap_v
);

    logic [MEM_ADDR_BITS-1:0] base_q   [NUM_TEX_UNITS];
    tex_format_e              format_q [NUM_TEX_UNITS];
    logic [DIM_LOG2_BITS-1:0] width_q  [NUM_TEX_UNITS];
    logic [DIM_LOG2_BITS-1:0] height_q [NUM_TEX_UNITS];
    wrap_mode_e               wrap_u_q [NUM_TEX_UNITS];
    wrap_mode_e               wrap_v_q [NUM_TEX_UNITS];

    logic [CSR_ADDR_BITS-1:0] ofs;
    logic                     in_range;
    logic [TEX_UNIT_BITS-1:0] wr_unit;
    tex_csr_e                 wr_reg;

    // unit in bit 3 of the offset, register in bits 2:0
    assign ofs      = csr_wr_addr - CSR_TEX_BEGIN;
    assign in_range = (csr_wr_addr >= CSR_TEX_BEGIN) && (csr_wr_addr <= CSR_TEX_END);
    assign wr_unit  = ofs[3 +: TEX_UNIT_BITS];
    assign wr_reg   = tex_csr_e'(ofs[2:0]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_TEX_UNITS; i++) begin
                base_q[i]   <= '0;
                format_q[i] <= FMT_RGBA8;
                width_q[i]  <= '0;
                height_q[i] <= '0;
                wrap_u_q[i] <= WRAP_CLAMP;
                wrap_v_q[i] <= WRAP_CLAMP;
            end
        end else if (csr_wr_en && in_range) begin
            case (wr_reg)
                CSR_OFS_ADDR:   base_q[wr_unit]   <= csr_wr_data[MEM_ADDR_BITS-1:0];
                CSR_OFS_FORMAT: format_q[wr_unit] <= tex_format_e'(csr_wr_data[0]);
                CSR_OFS_WIDTH:  width_q[wr_unit]  <= csr_wr_data[DIM_LOG2_BITS-1:0];
                CSR_OFS_HEIGHT: height_q[wr_unit] <= csr_wr_data[DIM_LOG2_BITS-1:0];
                CSR_OFS_WRAP_U: wrap_u_q[wr_unit] <= wrap_mode_e'(csr_wr_data[1:0]);
                CSR_OFS_WRAP_V: wrap_v_q[wr_unit] <= wrap_mode_e'(csr_wr_data[1:0]);
                default: ;
            endcase
        end
    end

    // fields of the requesting unit
    assign rd_base        = base_q[rd_unit];
    assign rd_format      = format_q[rd_unit];
    assign rd_width_log2  = width_q[rd_unit];
    assign rd_height_log2 = height_q[rd_unit];
    assign rd_wrap_u      = wrap_u_q[rd_unit];
    assign rd_wrap_v      = wrap_v_q[rd_unit];

endmodule

`default_nettype wire

// File: tex/tex_mem.sv
`default_nettype none

module tex_mem
    import tex_pkg::*;
(
    input  wire                                       clk,
    input  wire                                       rd_en,
    input  wire  [NUM_THREADS-1:0][MEM_ADDR_BITS-1:0] rd_addr,
    input  wire                                       wr_en,
    input  wire  [MEM_ADDR_BITS-1:0]                  wr_addr,
    input  wire  [TEXEL_BITS-1:0]                     wr_data,
    output logic [NUM_THREADS-1:0][TEXEL_BITS-1:0]    rd_data
);

    logic [TEXEL_BITS-1:0] mem [MEM_DEPTH];

    // load port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one read port per lane, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                rd_data[t] <= mem[rd_addr[t]];
            end
        end
    end

endmodule

`default_nettype wire

// File: tex/tex_unit.sv
`default_nettype none

module tex_unit
    import tex_pkg::*;
(
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     csr_wr_en,
    input  wire  [CSR_ADDR_BITS-1:0]                csr_wr_addr,
    input  wire  [CSR_WIDTH-1:0]                    csr_wr_data,
    input  wire                                     mem_wr_en,
    input  wire  [MEM_ADDR_BITS-1:0]                mem_wr_addr,
    input  wire  [TEXEL_BITS-1:0]                   mem_wr_data,
    input  wire                                     req_valid,
    output logic                                    req_ready,
    input  wire  [TEX_UNIT_BITS-1:0]                req_unit,
    input  wire  [NW_BITS-1:0]                      req_wid,
    input  wire  [NUM_THREADS-1:0]                  req_tmask,
    input  wire  [PC_BITS-1:0]                      req_pc,
    input  wire  [NR_BITS-1:0]                      req_rd,
    input  wire                                     req_wb,
    input  wire  [NUM_THREADS-1:0][COORD_BITS-1:0]  req_u,
    input  wire  [NUM_THREADS-1:0][COORD_BITS-1:0]  req_v,
    output logic                                    rsp_valid,
    input  wire                                     rsp_ready,
    output logic [NW_BITS-1:0]                      rsp_wid,
    output logic [NUM_THREADS-1:0]                  rsp_tmask,
    output logic [PC_BITS-1:0]                      rsp_pc,
    output logic [NR_BITS-1:0]                      rsp_rd,
    output logic                                    rsp_wb,
    output logic [NUM_THREADS-1:0][TEXEL_BITS-1:0]  rsp_data
);

    logic advance;

    logic [MEM_ADDR_BITS-1:0] csr_base;
    tex_format_e              csr_format;
    logic [DIM_LOG2_BITS-1:0] csr_width_log2;
    logic [DIM_LOG2_BITS-1:0] csr_height_log2;
    wrap_mode_e               csr_wrap_u;
    wrap_mode_e               csr_wrap_v;

    // stage 1: addresses
    logic                                      s1_valid;
    logic [NUM_THREADS-1:0][MEM_ADDR_BITS-1:0] s1_addr;
    logic [NUM_THREADS-1:0][1:0]               s1_byte_sel;
    logic [NW_BITS-1:0]                        s1_wid;
    logic [NUM_THREADS-1:0]                    s1_tmask;
    logic [PC_BITS-1:0]                        s1_pc;
    logic [NR_BITS-1:0]                        s1_rd;
    logic                                      s1_wb;
    tex_format_e                               s1_format;

    // stage 2: texel words
    logic                                      s2_valid;
    logic [NUM_THREADS-1:0][TEXEL_BITS-1:0]    s2_word;
    logic [NUM_THREADS-1:0][TEXEL_BITS-1:0]    s2_color;
    logic [NUM_THREADS-1:0][1:0]               s2_byte_sel;
    logic [NW_BITS-1:0]                        s2_wid;
    logic [NUM_THREADS-1:0]                    s2_tmask;
    logic [PC_BITS-1:0]                        s2_pc;
    logic [NR_BITS-1:0]                        s2_rd;
    logic                                      s2_wb;
    tex_format_e                               s2_format;

    // whole pipe freezes while a response waits
    assign advance   = !(rsp_valid && !rsp_ready);
    assign req_ready = advance;

    tex_csr csr_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .csr_wr_en      (csr_wr_en),
        .csr_wr_addr    (csr_wr_addr),
        .csr_wr_data    (csr_wr_data),
        .rd_unit        (req_unit),
        .rd_base        (csr_base),
        .rd_format      (csr_format),
        .rd_width_log2  (csr_width_log2),
        .rd_height_log2 (csr_height_log2),
        .rd_wrap_u      (csr_wrap_u),
        .rd_wrap_v      (csr_wrap_v)
    );

    tex_addr_gen addr_gen_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .in_valid    (req_valid),
        .u           (req_u),
        .v           (req_v),
        .base        (csr_base),
        .width_log2  (csr_width_log2),
        .height_log2 (csr_height_log2),
        .wrap_u      (csr_wrap_u),
        .wrap_v      (csr_wrap_v),
        .format      (csr_format),
        .word_addr   (s1_addr),
        .byte_sel    (s1_byte_sel),
        .out_valid   (s1_valid)
    );

    tex_mem mem_i (
        .clk     (clk),
        .rd_en   (advance),
        .rd_addr (s1_addr),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_data (s2_word)
    );

    for (genvar t = 0; t < NUM_THREADS; t++) begin : g_unpack
        tex_unpack unpack_i (
            .word     (s2_word[t]),
            .format   (s2_format),
            .byte_sel (s2_byte_sel[t]),
            .color    (s2_color[t])
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else if (advance) begin
            s2_valid  <= s1_valid;
            rsp_valid <= s2_valid;
        end
    end

    // metadata follows the valid bits
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_wid      <= req_wid;
            s1_tmask    <= req_tmask;
            s1_pc       <= req_pc;
            s1_rd       <= req_rd;
            s1_wb       <= req_wb;
            s1_format   <= csr_format;
            s2_wid      <= s1_wid;
            s2_tmask    <= s1_tmask;
            s2_pc       <= s1_pc;
            s2_rd       <= s1_rd;
            s2_wb       <= s1_wb;
            s2_format   <= s1_format;
            s2_byte_sel <= s1_byte_sel;
            rsp_wid     <= s2_wid;
            rsp_tmask   <= s2_tmask;
            rsp_pc      <= s2_pc;
            rsp_rd      <= s2_rd;
            rsp_wb      <= s2_wb;
            rsp_data    <= s2_color;
        end
    end

endmodule

`default_nettype wire

// File: tex/tex_unpack.sv
`default_nettype none

module tex_unpack
    import tex_pkg::*;
(
    input  wire  [TEXEL_BITS-1:0] word,
    input  wire tex_format_e      format,
    input  wire  [1:0]            byte_sel,
    output logic [TEXEL_BITS-1:0] color
);

    logic [7:0] red;

    // byte 0 is the least significant
    assign red = word[{byte_sel, 3'b000} +: 8];

    always_comb begin
        if (format == FMT_R8) begin
            color                   = '0;
            color[7:0]              = red;
            color[TEXEL_BITS-1 -: 8] = 8'hFF;
        end else begin
            color = word;
        end
    end

endmodule

`default_nettype wire
